/* build.f */
design/isaPkg.sv
design/pipePkg.sv
design/regFileBypass.sv
design/aluUnit.sv
design/memUnit.sv
design/decodeStage.sv
design/writeback.sv
design/mipsLite.sv
bench/mipsLiteTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module mipsLiteTb -o simv
./obj_dir/simv | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

/* bench/corePatterns.txt */
# test name instruction illegal writesReg dest value, one row per instruction in retire order
# instruction and value are hex, the other columns decimal
1 rtype 3c01ffff 0 1 1 ffff0000
1 rtype 3421fff0 0 1 1 fffffff0
1 rtype 24020005 0 1 2 00000005
1 rtype 00221821 0 1 3 fffffff5
1 rtype 00412023 0 1 4 00000015
1 rtype 00222824 0 1 5 00000000
1 rtype 00222825 0 1 5 fffffff5
1 rtype 00233026 0 1 6 00000005
1 rtype 00223827 0 1 7 0000000a
1 rtype 0022402a 0 1 8 00000001
1 rtype 0022482b 0 1 9 00000000
1 rtype 00025100 0 1 10 00000050
1 rtype 00015a02 0 1 11 00ffffff
1 rtype 00016103 0 1 12 ffffffff
2 immed 244dfff8 0 1 13 fffffffd
2 immed 282efff1 0 1 14 00000001
2 immed 2c4fffff 0 1 15 00000001
2 immed 3030ff0f 0 1 16 0000ff00
2 immed 34118001 0 1 17 00008001
2 immed 3832ffff 0 1 18 ffff000f
2 immed 3c131234 0 1 19 12340000
3 memlanes 36745678 0 1 20 12345678
3 memlanes ac140040 0 0 20 12345678
3 memlanes a0020041 0 0 2 00000005
3 memlanes a4010042 0 0 1 fffffff0
3 memlanes 8c150040 0 1 21 1205fff0
3 memlanes 80160041 0 1 22 00000005
3 memlanes 80170042 0 1 23 ffffffff
3 memlanes 90180043 0 1 24 000000f0
3 memlanes 84190042 0 1 25 fffffff0
3 memlanes 941a0040 0 1 26 00001205
4 forward 8c030040 0 1 3 1205fff0
4 forward 24640001 0 1 4 1205fff1
4 forward 00842021 0 1 4 240bffe2
4 forward ac040044 0 0 4 240bffe2
4 forward 8c050044 0 1 5 240bffe2
4 forward 00a33023 0 1 6 1205fff2
5 stallchain 24070100 0 1 7 00000100
5 stallchain 24e70100 0 1 7 00000200
5 stallchain 00073840 0 1 7 00000400
5 stallchain a0070047 0 0 7 00000400
5 stallchain 8c080044 0 1 8 240bff00
6 illegalzero fc221234 1 0 2 00000000
6 illegalzero 0022183f 1 0 3 00000000
6 illegalzero 00434821 0 1 9 1205fff5
6 illegalzero 24200077 0 1 0 00000067
6 illegalzero 00025021 0 1 10 00000005

/* bench/mipsLiteTb.sv */
`timescale 1ns/1ps

module mipsLiteTb;

  import isaPkg::*;
  import pipePkg::*;

  localparam int  maxRecs  = 256;
  localparam int  maxTests = 16;
  localparam int  nameLen  = 24;
  // ASCII '#'
  localparam byte hashChar = 8'h23;

  logic      clk;
  logic      rst;
  logic      inValid;
  wordT      inWord;
  logic      retReady;
  logic      inReady;
  logic      retValid;
  retireRecT retRec;

  // One row per instruction, paired with its retire record
  wordT      instrs     [maxRecs];
  retireRecT expRecs    [maxRecs];
  int        recTest    [maxRecs];
  string     testNames  [maxTests];
  int        testErrors [maxTests];
  int        recCount     = 0;
  int        recordErrors = 0;
  int        setupErrors  = 0;
  int        extraErrors  = 0;
  int        testsPassed  = 0;
  int        testsFailed  = 0;

  mipsLite dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inWord   (inWord),
    .retReady (retReady),
    .inReady  (inReady),
    .retValid (retValid),
    .retRec   (retRec)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ********************
  // Helpers
  // ********************

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Packed scan buffer to string, dropping the zero padding
  function automatic string bitsToName(input logic [8*nameLen-1:0] bits);
    string s;
    s = "";
    for (int i = nameLen - 1; i >= 0; i--) begin
      if (bits[i*8 +: 8] != 8'h00) s = $sformatf("%s%c", s, bits[i*8 +: 8]);
    end
    return s;
  endfunction

  task automatic loadPatterns();
    int                   fd;
    int                   n;
    int                   testNum;
    int                   illegalBit;
    int                   writesBit;
    int                   destNum;
    logic [31:0]          word;
    logic [31:0]          value;
    logic [8*nameLen-1:0] nameBits;
    string                line;
    fd = $fopen("bench/corePatterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file bench/corePatterns.txt");
      setupErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != hashChar) begin
          nameBits = '0;
          n = $sscanf(line, "%d %s %h %d %d %d %h", testNum, nameBits, word,
                      illegalBit, writesBit, destNum, value);
          if (n == 7 && recCount < maxRecs && testNum > 0 && testNum < maxTests) begin
            instrs[recCount]   = word;
            expRecs[recCount]  = '{illegal: illegalBit[0], writesReg: writesBit[0],
                                   dest: destNum[4:0], value: value};
            recTest[recCount]  = testNum;
            testNames[testNum] = bitsToName(nameBits);
            recCount++;
          end else begin
            $display("Pattern line could not be parsed: %s", line);
            setupErrors++;
          end
        end
      end
      $fclose(fd);
    end
    if (recCount == 0) begin
      $display("The pattern file holds no instructions");
      setupErrors++;
    end
  endtask

  // Compare one retire handshake, close the test on its last record
  task automatic checkRecord(input int idx);
    int t;
    t = recTest[idx];
    // Fields shown as illegal/writesReg/dest/value
    assert (retRec == expRecs[idx]) else begin
      $display("FAIL %s rec %0d expected %0b/%0b/r%0d/%08h actual %0b/%0b/r%0d/%08h",
               testNames[t], idx, expRecs[idx].illegal, expRecs[idx].writesReg,
               expRecs[idx].dest, expRecs[idx].value, retRec.illegal,
               retRec.writesReg, retRec.dest, retRec.value);
      testErrors[t]++;
      recordErrors++;
    end
    if (idx == recCount - 1 || recTest[idx + 1] != t) begin
      if (testErrors[t] == 0) begin
        $display("Test %0d %s: pass", t, testNames[t]);
        testsPassed++;
      end else begin
        $display("Test %0d %s: %0d wrong records", t, testNames[t], testErrors[t]);
        testsFailed++;
      end
    end
  endtask

  // ********************
  // Stimulus and scoreboard
  // ********************

  initial begin
    int          inIdx;
    int          outIdx;
    int          cycles;
    int          limit;
    logic [31:0] rng;
    logic        timedOut;
    rst      = 1'b1;
    inValid  = 1'b0;
    inWord   = '0;
    retReady = 1'b0;
    inIdx    = 0;
    outIdx   = 0;
    cycles   = 0;
    rng      = 32'd98;
    for (int i = 0; i < maxTests; i++) begin
      testErrors[i] = 0;
    end
    loadPatterns();
    limit = 4 * recCount + 40;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #5;
    assert (inReady && !retValid) else begin
      $display("DUT is not idle after reset");
      setupErrors++;
    end
    @(negedge clk);

    while (outIdx < recCount && cycles < limit) begin
      // Random stalls on both streams
      rng      = lcgNext(rng);
      retReady = (rng[22:21] != 2'b00);
      rng      = lcgNext(rng);
      if (inIdx < recCount) begin
        inValid = (rng[24:23] != 2'b00);
        inWord  = instrs[inIdx];
      end else begin
        inValid = 1'b0;
        inWord  = '0;
      end
      // Outputs are settled well before the next rising edge
      #5;
      if (retValid && retReady) begin
        checkRecord(outIdx);
        outIdx++;
      end
      if (inValid && inReady) inIdx++;
      @(negedge clk);
      cycles++;
    end

    timedOut = (outIdx < recCount);
    if (timedOut) begin
      $display("Timeout after %0d cycles, retire records stopped arriving (%0d of %0d)",
               cycles, outIdx, recCount);
    end else begin
      // Nothing may retire past the last expected record
      repeat (4) begin
        inValid  = 1'b0;
        inWord   = '0;
        retReady = 1'b1;
        #5;
        assert (!retValid) else begin
          $display("Unexpected retire record after the last one, value %08h", retRec.value);
          extraErrors++;
        end
        @(negedge clk);
      end
    end

    $display("Records checked %0d of %0d, mismatches %0d, tests passed %0d, tests failed %0d",
             outIdx, recCount, recordErrors, testsPassed, testsFailed);
    if (timedOut || recordErrors + setupErrors + extraErrors != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule

/* design/mipsLite.sv */
`timescale 1ns/1ps

module mipsLite #(
  parameter int dataWords = 256
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  input  isaPkg::wordT       inWord,
  input  logic               retReady,
  output logic               inReady,
  output logic               retValid,
  output pipePkg::retireRecT retRec
);

  import isaPkg::*;
  import pipePkg::*;

  decodedOpT opE;
  wordT      opA;
  wordT      opB;
  wordT      aluResult;
  wordT      loadValue;
  logic      wbWrite;
  regIdxT    wbDest;
  wordT      wbValue;
  logic      hold;

  // ********************
  // Decode
  // ********************

  decodeStage decode (
    .clk     (clk),
    .rst     (rst),
    .inValid (inValid),
    .inWord  (inWord),
    .hold    (hold),
    .inReady (inReady),
    .opE     (opE)
  );

  // ********************
  // Execute
  // ********************

  regFileBypass regs (
    .clk     (clk),
    .rst     (rst),
    .rs      (opE.rs),
    .rt      (opE.rt),
    .wbWrite (wbWrite),
    .wbDest  (wbDest),
    .wbValue (wbValue),
    .opA     (opA),
    .opB     (opB)
  );

  aluUnit alu (
    .opE       (opE),
    .opA       (opA),
    .opB       (opB),
    .aluResult (aluResult)
  );

  // Spans execute and memory because the RAM read is registered
  memUnit #(
    .dataWords (dataWords)
  ) mem (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .opE       (opE),
    .opA       (opA),
    .opB       (opB),
    .loadValue (loadValue)
  );

  // ********************
  // Memory and writeback
  // ********************

  writeback wb (
    .clk       (clk),
    .rst       (rst),
    .opE       (opE),
    .aluResult (aluResult),
    .loadValue (loadValue),
    .retReady  (retReady),
    .retValid  (retValid),
    .retRec    (retRec),
    .wbWrite   (wbWrite),
    .wbDest    (wbDest),
    .wbValue   (wbValue),
    .hold      (hold)
  );

endmodule

/* design/writeback.sv */
`timescale 1ns/1ps

module writeback (
  input  logic               clk,
  input  logic               rst,
  input  pipePkg::decodedOpT opE,
  input  isaPkg::wordT       aluResult,
  input  isaPkg::wordT       loadValue,
  input  logic               retReady,
  output logic               retValid,
  output pipePkg::retireRecT retRec,
  output logic               wbWrite,
  output isaPkg::regIdxT     wbDest,
  output isaPkg::wordT       wbValue,
  output logic               hold
);

  import isaPkg::*;

  logic   validM;
  logic   illegalM;
  logic   writesRegM;
  logic   isLoadM;
  regIdxT destM;
  wordT   aluM;

  // ********************
  // Execute to memory
  // ********************

  always_ff @(posedge clk) begin
    if (rst) begin
      validM     <= 1'b0;
      illegalM   <= 1'b0;
      writesRegM <= 1'b0;
      isLoadM    <= 1'b0;
    end else if (!hold) begin
      validM     <= opE.valid;
      illegalM   <= opE.illegal;
      writesRegM <= opE.writesReg;
      isLoadM    <= opE.isLoad;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      destM <= opE.dest;
      aluM  <= aluResult;
    end
  end

  // Result merge, stores already carry rt in aluM
  assign wbValue = isLoadM ? loadValue : aluM;
  assign wbDest  = destM;

  // Whole pipeline stalls while a record waits
  assign hold     = validM && !retReady;
  assign retValid = validM;
  assign wbWrite  = validM && writesRegM && !hold && (destM != '0);

  assign retRec = '{illegal: illegalM, writesReg: writesRegM, dest: destM, value: wbValue};

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
  input  logic              clk,
  input  logic              rst,
  input  logic              inValid,
  input  isaPkg::wordT      inWord,
  input  logic              hold,
  output logic              inReady,
  output pipePkg::decodedOpT opE
);

  import isaPkg::*;
  import pipePkg::*;

  opcodeT    opcode;
  functT     funct;
  decodedOpT dec;
  logic      accept;

  assign opcode  = opcodeT'(inWord[opcodeHi:opcodeLo]);
  assign funct   = functT'(inWord[functHi:functLo]);
  assign inReady = !hold;
  assign accept  = inValid && !hold;

  // ********************
  // Instruction decoder
  // ********************

  always_comb begin
    dec           = '0;
    dec.valid     = 1'b1;
    dec.rs        = inWord[rsHi:rsLo];
    dec.rt        = inWord[rtHi:rtLo];
    dec.shamt     = inWord[shamtHi:shamtLo];
    dec.dest      = inWord[rtHi:rtLo];
    dec.writesReg = 1'b1;
    dec.useImm    = 1'b1;
    dec.aluOp     = aluPass;
    dec.memSize   = memWord;
    dec.imm       = {{16{inWord[immHi]}}, inWord[immHi:immLo]};
    case (opcode)
      opSpecial: begin
        dec.dest   = inWord[rdHi:rdLo];
        dec.useImm = 1'b0;
        case (funct)
          fnSll: begin
            dec.aluOp    = aluSll;
            dec.useShamt = 1'b1;
          end
          fnSrl: begin
            dec.aluOp    = aluSrl;
            dec.useShamt = 1'b1;
          end
          fnSra: begin
            dec.aluOp    = aluSra;
            dec.useShamt = 1'b1;
          end
          fnAddu:  dec.aluOp = aluAdd;
          fnSubu:  dec.aluOp = aluSub;
          fnAnd:   dec.aluOp = aluAnd;
          fnOr:    dec.aluOp = aluOr;
          fnXor:   dec.aluOp = aluXor;
          fnNor:   dec.aluOp = aluNor;
          fnSlt:   dec.aluOp = aluSlt;
          fnSltu:  dec.aluOp = aluSltu;
          default: dec.illegal = 1'b1;
        endcase
      end
      opAddiu: dec.aluOp = aluAdd;
      opSlti:  dec.aluOp = aluSlt;
      opSltiu: dec.aluOp = aluSltu;
      opAndi, opOri, opXori, opLui: begin
        dec.imm = {16'h0000, inWord[immHi:immLo]};
        case (opcode)
          opAndi:  dec.aluOp = aluAnd;
          opOri:   dec.aluOp = aluOr;
          opXori:  dec.aluOp = aluXor;
          default: dec.aluOp = aluLui;
        endcase
      end
      opLb, opLh, opLw, opLbu, opLhu: begin
        dec.aluOp        = aluAdd;
        dec.isLoad       = 1'b1;
        dec.loadUnsigned = (opcode == opLbu) || (opcode == opLhu);
        if (opcode == opLb || opcode == opLbu) dec.memSize = memByte;
        else if (opcode == opLh || opcode == opLhu) dec.memSize = memHalf;
      end
      // Stores pass rt through so it shows up in the retire record
      opSb, opSh, opSw: begin
        dec.isStore   = 1'b1;
        dec.writesReg = 1'b0;
        dec.useImm    = 1'b0;
        if (opcode == opSb) dec.memSize = memByte;
        else if (opcode == opSh) dec.memSize = memHalf;
      end
      default: dec.illegal = 1'b1;
    endcase
    // Illegal words retire with a zero value and no side effects
    if (dec.illegal) begin
      dec.writesReg = 1'b0;
      dec.isLoad    = 1'b0;
      dec.isStore   = 1'b0;
      dec.useImm    = 1'b1;
      dec.imm       = '0;
      dec.aluOp     = aluPass;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      opE <= '0;
    end else if (accept) begin
      opE <= dec;
    end else if (!hold) begin
      opE.valid <= 1'b0;
    end
  end

endmodule

/* design/memUnit.sv */
`timescale 1ns/1ps

module memUnit #(
  parameter int dataWords = 256
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               hold,
  input  pipePkg::decodedOpT opE,
  input  isaPkg::wordT       opA,
  input  isaPkg::wordT       opB,
  output isaPkg::wordT       loadValue
);

  import isaPkg::*;
  import pipePkg::*;

  // dataWords is a power of two, so the slice wraps the address
  localparam int addrBits = $clog2(dataWords);

  wordT                ram [dataWords];
  wordT                addr;
  logic [addrBits-1:0] wordIdx;
  logic [3:0]          byteMask;
  wordT                storeData;
  memCtlT              ctlM;
  wordT                readWordM;
  logic [15:0]         halfSel;
  logic [7:0]          byteSel;

  // ********************
  // Execute side
  // ********************

  assign addr    = opA + opE.imm;
  assign wordIdx = addr[addrBits+1:2];

  // Big endian lanes, offset 0 lives in bits 31:24
  always_comb begin
    case (opE.memSize)
      memByte: begin
        byteMask  = 4'b1000 >> addr[1:0];
        storeData = {4{opB[7:0]}};
      end
      memHalf: begin
        byteMask  = addr[1] ? 4'b0011 : 4'b1100;
        storeData = {2{opB[15:0]}};
      end
      default: begin
        byteMask  = 4'b1111;
        storeData = opB;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      if (opE.valid && opE.isStore) begin
        for (int b = 0; b < 4; b++) begin
          if (byteMask[b]) ram[wordIdx][b*8 +: 8] <= storeData[b*8 +: 8];
        end
      end
      readWordM <= ram[wordIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctlM <= '0;
    end else if (!hold) begin
      ctlM <= '{byteOff: addr[1:0], memSize: opE.memSize,
                loadUnsigned: opE.loadUnsigned};
    end
  end

  // ********************
  // Memory stage
  // ********************

  assign halfSel = ctlM.byteOff[1] ? readWordM[15:0] : readWordM[31:16];
  assign byteSel = ctlM.byteOff[0] ? halfSel[7:0] : halfSel[15:8];

  always_comb begin
    case (ctlM.memSize)
      memByte: loadValue = {{24{byteSel[7] & ~ctlM.loadUnsigned}}, byteSel};
      memHalf: loadValue = {{16{halfSel[15] & ~ctlM.loadUnsigned}}, halfSel};
      default: loadValue = readWordM;
    endcase
  end

endmodule

/* design/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
  input  pipePkg::decodedOpT opE,
  input  isaPkg::wordT       opA,
  input  isaPkg::wordT       opB,
  output isaPkg::wordT       aluResult
);

  import isaPkg::*;

  wordT       opBSel;
  logic [4:0] shiftAmt;

  // Operand select
  assign opBSel   = opE.useImm ? opE.imm : opB;
  assign shiftAmt = opE.useShamt ? opE.shamt : opA[4:0];

  always_comb begin
    case (opE.aluOp)
      aluAdd: begin
        aluResult = opA + opBSel;
      end
      aluSub: begin
        aluResult = opA - opBSel;
      end
      aluAnd: begin
        aluResult = opA & opBSel;
      end
      aluOr: begin
        aluResult = opA | opBSel;
      end
      aluXor: begin
        aluResult = opA ^ opBSel;
      end
      aluNor: begin
        aluResult = ~(opA | opBSel);
      end
      aluSlt: begin
        aluResult = {31'b0, $signed(opA) < $signed(opBSel)};
      end
      aluSltu: begin
        aluResult = {31'b0, opA < opBSel};
      end
      // Shifts work on rt, as in MIPS
      aluSll: begin
        aluResult = opBSel << shiftAmt;
      end
      aluSrl: begin
        aluResult = opBSel >> shiftAmt;
      end
      aluSra: begin
        aluResult = $signed(opBSel) >>> shiftAmt;
      end
      aluLui: begin
        aluResult = {opBSel[15:0], 16'h0000};
      end
      default: begin
        aluResult = opBSel;
      end
    endcase
  end

endmodule

/* design/regFileBypass.sv */
`timescale 1ns/1ps

module regFileBypass (
  input  logic            clk,
  input  logic            rst,
  input  isaPkg::regIdxT  rs,
  input  isaPkg::regIdxT  rt,
  input  logic            wbWrite,
  input  isaPkg::regIdxT  wbDest,
  input  isaPkg::wordT    wbValue,
  output isaPkg::wordT    opA,
  output isaPkg::wordT    opB
);

  import isaPkg::*;

  wordT regs [32];

  // wbWrite never targets r0, so it stays cleared from reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite) begin
      regs[wbDest] <= wbValue;
    end
  end

  // Memory-stage result wins over the stored copy
  assign opA = (rs == '0) ? '0 :
               (wbWrite && wbDest == rs) ? wbValue : regs[rs];
  assign opB = (rt == '0) ? '0 :
               (wbWrite && wbDest == rt) ? wbValue : regs[rt];

endmodule

/* design/pipePkg.sv */
package pipePkg;

  import isaPkg::*;

  // ********************
  // Decode to execute
  // ********************

  typedef struct packed {
    logic    valid;
    aluOpT   aluOp;
    regIdxT  rs;
    regIdxT  rt;
    regIdxT  dest;
    logic    writesReg;
    // B operand comes from imm instead of rt
    logic    useImm;
    // Shift amount from the instruction field
    logic    useShamt;
    logic [4:0] shamt;
    // Already sign or zero extended
    wordT    imm;
    logic    isLoad;
    logic    isStore;
    memSizeT memSize;
    logic    loadUnsigned;
    logic    illegal;
  } decodedOpT;

  // ********************
  // Execute to memory
  // ********************

  // What load extraction needs one cycle after the RAM read
  typedef struct packed {
    logic [1:0] byteOff;
    memSizeT    memSize;
    logic       loadUnsigned;
  } memCtlT;

  // ********************
  // Retire stream
  // ********************

  typedef struct packed {
    logic   illegal;
    logic   writesReg;
    regIdxT dest;
    wordT   value;
  } retireRecT;

endpackage

/* design/isaPkg.sv */
package isaPkg;

  // ********************
  // Basic data types
  // ********************

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;

  // Instruction field positions
  localparam int opcodeHi = 31;
  localparam int opcodeLo = 26;
  localparam int rsHi     = 25;
  localparam int rsLo     = 21;
  localparam int rtHi     = 20;
  localparam int rtLo     = 16;
  localparam int rdHi     = 15;
  localparam int rdLo     = 11;
  localparam int shamtHi  = 10;
  localparam int shamtLo  = 6;
  localparam int functHi  = 5;
  localparam int functLo  = 0;
  localparam int immHi    = 15;
  localparam int immLo    = 0;

  // ********************
  // Encodings
  // ********************

  typedef enum logic [5:0] {
    opSpecial = 6'h00,
    opAddiu   = 6'h09,
    opSlti    = 6'h0a,
    opSltiu   = 6'h0b,
    opAndi    = 6'h0c,
    opOri     = 6'h0d,
    opXori    = 6'h0e,
    opLui     = 6'h0f,
    opLb      = 6'h20,
    opLh      = 6'h21,
    opLw      = 6'h23,
    opLbu     = 6'h24,
    opLhu     = 6'h25,
    opSb      = 6'h28,
    opSh      = 6'h29,
    opSw      = 6'h2b
  } opcodeT;

  // Only the fixed-amount shifts exist
  typedef enum logic [5:0] {
    fnSll  = 6'h00,
    fnSrl  = 6'h02,
    fnSra  = 6'h03,
    fnAddu = 6'h21,
    fnSubu = 6'h23,
    fnAnd  = 6'h24,
    fnOr   = 6'h25,
    fnXor  = 6'h26,
    fnNor  = 6'h27,
    fnSlt  = 6'h2a,
    fnSltu = 6'h2b
  } functT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt,
    aluSltu, aluSll, aluSrl, aluSra, aluLui, aluPass
  } aluOpT;

  // Code is the byte count minus one
  typedef enum logic [1:0] {
    memByte = 2'b00,
    memHalf = 2'b01,
    memWord = 2'b11
  } memSizeT;

endpackage
